// File: hdl/exu_pkg.sv
package exu_pkg;

   // widths fixed by the instruction set
   localparam int data_w     = 32;
   localparam int reg_addr_w = 5;
   localparam int pc_w       = 32;
   localparam int reg_count  = 32;

   typedef logic [data_w-1:0]     data_t;
   typedef logic [reg_addr_w-1:0] reg_addr_t;
   typedef logic [pc_w-1:0]       pc_t;

   // link address is pc of the jump plus one instruction
   localparam pc_t link_offset = 32'd4;

   typedef enum logic [1:0] {
      unit_alu,
      unit_bru,
      unit_mul
   } unit_e;

   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_slt,
      alu_sltu,
      alu_passb
   } alu_op_e;

   typedef enum logic [2:0] {
      bru_beq,
      bru_bne,
      bru_blt,
      bru_bge,
      bru_bltu,
      bru_bgeu,
      bru_jal,
      bru_jalr
   } bru_op_e;

   typedef enum logic [1:0] {
      mul_mul,
      mul_mulh,
      mul_mulhu
   } mul_op_e;

   typedef struct packed {
      unit_e     unit;
      alu_op_e   alu_op;
      bru_op_e   bru_op;
      mul_op_e   mul_op;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      logic      use_imm;
      data_t     imm;
      pc_t       pc;
   } issue_t;

   typedef struct packed {
      reg_addr_t rd;
      logic      wen;
      data_t     data;
      logic      br_taken;
      pc_t       br_target;
   } wb_t;

endpackage

// File: hdl/exu_regfile.sv
`timescale 1ns/100ps

module exu_regfile (
   input  logic              clk,
   input  logic              rst_n,
   input  exu_pkg::reg_addr_t rs1,
   input  exu_pkg::reg_addr_t rs2,
   output exu_pkg::data_t    rs1_data,
   output exu_pkg::data_t    rs2_data,
   input  logic              we,
   input  exu_pkg::reg_addr_t wa,
   input  exu_pkg::data_t    wd
);

   // entry 0 is not stored, it always reads zero
   exu_pkg::data_t regs [1:exu_pkg::reg_count-1];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < exu_pkg::reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wa != '0)) begin
         regs[wa] <= wd;
      end
   end

   function automatic exu_pkg::data_t read_port(exu_pkg::reg_addr_t ra);
      if (ra == '0) begin
         return '0;
      end else if (we && (wa == ra)) begin
         // write-through of the value landing this edge
         return wd;
      end
      return regs[ra];
   endfunction

   always_comb begin
      rs1_data = read_port(rs1);
      rs2_data = read_port(rs2);
   end

endmodule

// File: hdl/exu_alu.sv
`timescale 1ns/100ps

module exu_alu (
   input  exu_pkg::data_t   a,
   input  exu_pkg::data_t   b,
   input  exu_pkg::alu_op_e op,
   output exu_pkg::data_t   res
);

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   // only the low 5 bits of b count for shifts
   assign shamt = b[4:0];

   assign lt_signed   = $signed(a) < $signed(b);
   assign lt_unsigned = a < b;

   always_comb begin
      case (op)
         exu_pkg::alu_add: begin
            res = a + b;
         end
         exu_pkg::alu_sub: begin
            res = a - b;
         end
         exu_pkg::alu_and: begin
            res = a & b;
         end
         exu_pkg::alu_or: begin
            res = a | b;
         end
         exu_pkg::alu_xor: begin
            res = a ^ b;
         end
         exu_pkg::alu_sll: begin
            res = a << shamt;
         end
         exu_pkg::alu_srl: begin
            res = a >> shamt;
         end
         exu_pkg::alu_sra: begin
            res = $signed(a) >>> shamt;
         end
         exu_pkg::alu_slt: begin
            res = {{(exu_pkg::data_w-1){1'b0}}, lt_signed};
         end
         exu_pkg::alu_sltu: begin
            res = {{(exu_pkg::data_w-1){1'b0}}, lt_unsigned};
         end
         // upper-immediate style, b already holds the value
         exu_pkg::alu_passb: begin
            res = b;
         end
         default: begin
            res = '0;
         end
      endcase
   end

endmodule

// File: hdl/exu_bru.sv
`timescale 1ns/100ps

module exu_bru (
   input  exu_pkg::bru_op_e op,
   input  exu_pkg::data_t   a,
   input  exu_pkg::data_t   b,
   input  exu_pkg::data_t   imm,
   input  exu_pkg::pc_t     pc,
   output logic             taken,
   output exu_pkg::pc_t     target,
   output exu_pkg::data_t   link
);

   logic         eq;
   logic         lt_s;
   logic         lt_u;
   exu_pkg::pc_t jalr_sum;

   assign eq   = (a == b);
   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         exu_pkg::bru_beq:  taken = eq;
         exu_pkg::bru_bne:  taken = !eq;
         exu_pkg::bru_blt:  taken = lt_s;
         exu_pkg::bru_bge:  taken = !lt_s;
         exu_pkg::bru_bltu: taken = lt_u;
         exu_pkg::bru_bgeu: taken = !lt_u;
         default:           taken = 1'b1;
      endcase
   end

   // jalr is register relative with bit 0 dropped
   assign jalr_sum = a + imm;
   assign target   = (op == exu_pkg::bru_jalr) ? {jalr_sum[exu_pkg::pc_w-1:1], 1'b0}
                                               : pc + imm;

   assign link = pc + exu_pkg::link_offset;

endmodule

// File: hdl/exu_mul.sv
`timescale 1ns/100ps

module exu_mul (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             advance,
   input  exu_pkg::data_t   a,
   input  exu_pkg::data_t   b,
   input  exu_pkg::mul_op_e op,
   output exu_pkg::data_t   res
);

   logic                sgn;
   logic signed [16:0]  a_hi;
   logic signed [16:0]  a_lo;
   logic signed [16:0]  b_hi;
   logic signed [16:0]  b_lo;
   logic signed [33:0]  pp_ll_q;
   logic signed [33:0]  pp_lh_q;
   logic signed [33:0]  pp_hl_q;
   logic signed [33:0]  pp_hh_q;
   exu_pkg::mul_op_e    op_q;
   logic signed [63:0]  hh;
   logic signed [63:0]  mid;
   logic signed [63:0]  ll;
   logic signed [63:0]  prod;

   // only mulhu treats the operands as unsigned
   assign sgn  = (op != exu_pkg::mul_mulhu);
   assign a_hi = {sgn & a[31], a[31:16]};
   assign b_hi = {sgn & b[31], b[31:16]};
   assign a_lo = {1'b0, a[15:0]};
   assign b_lo = {1'b0, b[15:0]};

   // first stage, partial products
   always_ff @(posedge clk) begin
      if (advance) begin
         pp_ll_q <= a_lo * b_lo;
         pp_lh_q <= a_lo * b_hi;
         pp_hl_q <= a_hi * b_lo;
         pp_hh_q <= a_hi * b_hi;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_q <= exu_pkg::mul_mul;
      end else if (advance) begin
         op_q <= op;
      end
   end

   // second stage sum, registered by the writeback stage
   assign hh   = pp_hh_q;
   assign mid  = pp_hl_q + pp_lh_q;
   assign ll   = pp_ll_q;
   assign prod = (hh <<< 32) + (mid <<< 16) + ll;

   assign res = (op_q == exu_pkg::mul_mul) ? prod[31:0] : prod[63:32];

endmodule

// File: hdl/exu_ctrl.sv
`timescale 1ns/100ps

module exu_ctrl (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               issue_valid,
   output logic               issue_ready,
   input  exu_pkg::issue_t    issue,
   input  exu_pkg::data_t     rs1_data,
   input  exu_pkg::data_t     rs2_data,
   output logic               rf_we,
   output exu_pkg::reg_addr_t rf_wa,
   output exu_pkg::data_t     rf_wd,
   output exu_pkg::data_t     op_a,
   output exu_pkg::data_t     op_b,
   output exu_pkg::alu_op_e   alu_op,
   input  exu_pkg::data_t     alu_res,
   output exu_pkg::bru_op_e   bru_op,
   output exu_pkg::data_t     bru_imm,
   output exu_pkg::pc_t       bru_pc,
   input  logic               bru_taken,
   input  exu_pkg::data_t     bru_target,
   input  exu_pkg::data_t     bru_link,
   output exu_pkg::data_t     mul_a,
   output exu_pkg::data_t     mul_b,
   output exu_pkg::mul_op_e   mul_op,
   output logic               mul_advance,
   input  exu_pkg::data_t     mul_res,
   output logic               wb_valid,
   input  logic               wb_ready,
   output exu_pkg::wb_t       wb
);

   logic            advance;
   exu_pkg::data_t  sel_b;
   logic            is_valid;
   exu_pkg::issue_t is_pkt;
   exu_pkg::data_t  is_a;
   exu_pkg::data_t  is_b;
   exu_pkg::wb_t    wb_d;

   // one stall condition for every stage
   assign advance     = !wb_valid || wb_ready;
   assign issue_ready = advance;
   assign mul_advance = advance;

   assign sel_b = issue.use_imm ? issue.imm : rs2_data;

   // multiplier takes its operands at acceptance
   assign mul_a  = rs1_data;
   assign mul_b  = sel_b;
   assign mul_op = issue.mul_op;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         is_valid <= 1'b0;
      end else if (advance) begin
         is_valid <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         is_pkt <= issue;
         is_a   <= rs1_data;
         is_b   <= sel_b;
      end
   end

   assign op_a    = is_a;
   assign op_b    = is_b;
   assign alu_op  = is_pkt.alu_op;
   assign bru_op  = is_pkt.bru_op;
   assign bru_imm = is_pkt.imm;
   assign bru_pc  = is_pkt.pc;

   // pick the unit result and apply the wen rules
   always_comb begin
      wb_d    = '0;
      wb_d.rd = is_pkt.rd;
      case (is_pkt.unit)
         exu_pkg::unit_alu: begin
            wb_d.wen  = 1'b1;
            wb_d.data = alu_res;
         end
         exu_pkg::unit_bru: begin
            wb_d.br_taken  = bru_taken;
            wb_d.br_target = bru_target;
            if ((is_pkt.bru_op == exu_pkg::bru_jal) || (is_pkt.bru_op == exu_pkg::bru_jalr)) begin
               wb_d.wen  = 1'b1;
               wb_d.data = bru_link;
            end
         end
         exu_pkg::unit_mul: begin
            wb_d.wen  = 1'b1;
            wb_d.data = mul_res;
         end
         default: begin
            wb_d.wen = 1'b0;
         end
      endcase
      if (is_pkt.rd == '0) begin
         wb_d.wen = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
      end else if (advance) begin
         wb_valid <= is_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         wb <= wb_d;
      end
   end

   // register write lands on the writeback handshake
   assign rf_we = wb_valid && wb_ready && wb.wen;
   assign rf_wa = wb.rd;
   assign rf_wd = wb.data;

endmodule

// File: hdl/exu_top.sv
`timescale 1ns/100ps

module exu_top (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            issue_valid,
   output logic            issue_ready,
   input  exu_pkg::issue_t issue,
   output logic            wb_valid,
   input  logic            wb_ready,
   output exu_pkg::wb_t    wb
);

   exu_pkg::data_t     rs1_data;
   exu_pkg::data_t     rs2_data;
   logic               rf_we;
   exu_pkg::reg_addr_t rf_wa;
   exu_pkg::data_t     rf_wd;
   exu_pkg::data_t     op_a;
   exu_pkg::data_t     op_b;
   exu_pkg::alu_op_e   alu_op;
   exu_pkg::data_t     alu_res;
   exu_pkg::bru_op_e   bru_op;
   exu_pkg::data_t     bru_imm;
   exu_pkg::pc_t       bru_pc;
   logic               bru_taken;
   exu_pkg::pc_t       bru_target;
   exu_pkg::data_t     bru_link;
   exu_pkg::data_t     mul_a;
   exu_pkg::data_t     mul_b;
   exu_pkg::mul_op_e   mul_op;
   logic               mul_advance;
   exu_pkg::data_t     mul_res;

   // read addresses come straight from the issue packet
   exu_regfile u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rs1      (issue.rs1),
      .rs2      (issue.rs2),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .we       (rf_we),
      .wa       (rf_wa),
      .wd       (rf_wd)
   );

   exu_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue       (issue),
      .rs1_data    (rs1_data),
      .rs2_data    (rs2_data),
      .rf_we       (rf_we),
      .rf_wa       (rf_wa),
      .rf_wd       (rf_wd),
      .op_a        (op_a),
      .op_b        (op_b),
      .alu_op      (alu_op),
      .alu_res     (alu_res),
      .bru_op      (bru_op),
      .bru_imm     (bru_imm),
      .bru_pc      (bru_pc),
      .bru_taken   (bru_taken),
      .bru_target  (bru_target),
      .bru_link    (bru_link),
      .mul_a       (mul_a),
      .mul_b       (mul_b),
      .mul_op      (mul_op),
      .mul_advance (mul_advance),
      .mul_res     (mul_res),
      .wb_valid    (wb_valid),
      .wb_ready    (wb_ready),
      .wb          (wb)
   );

   exu_alu u_alu (
      .a   (op_a),
      .b   (op_b),
      .op  (alu_op),
      .res (alu_res)
   );

   exu_bru u_bru (
      .op     (bru_op),
      .a      (op_a),
      .b      (op_b),
      .imm    (bru_imm),
      .pc     (bru_pc),
      .taken  (bru_taken),
      .target (bru_target),
      .link   (bru_link)
   );

   exu_mul u_mul (
      .clk     (clk),
      .rst_n   (rst_n),
      .advance (mul_advance),
      .a       (mul_a),
      .b       (mul_b),
      .op      (mul_op),
      .res     (mul_res)
   );

endmodule

// File: test/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
   parameter int period_ns    = 4,
   parameter int reset_cycles = 10
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      // release away from the sampling edge
      @(negedge clk);
      rst_n = 1'b1;
   end

   always #(period_ns / 2) clk = ~clk;

endmodule

// File: test/exu_sva.sv
`timescale 1ns/100ps

module exu_sva (
   input logic         clk,
   input logic         rst_n,
   input logic         issue_valid,
   input logic         issue_ready,
   input logic         wb_valid,
   input logic         wb_ready,
   input exu_pkg::wb_t wb
);

   // a stalled result holds until it is taken
   stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid && !wb_ready |=> wb_valid && $stable(wb))
      else $error("wb packet changed or dropped while stalled");

   // a result only shows up two edges after an accepted packet
   no_phantom: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(wb_valid) |-> $past(issue_valid && issue_ready, 2))
      else $error("wb_valid rose without a packet accepted two cycles before");

   // pipeline comes out of reset empty
   reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> !wb_valid && issue_ready)
      else $error("pipeline not empty after reset");

endmodule

bind exu_top exu_sva u_sva (
   .clk         (clk),
   .rst_n       (rst_n),
   .issue_valid (issue_valid),
   .issue_ready (issue_ready),
   .wb_valid    (wb_valid),
   .wb_ready    (wb_ready),
   .wb          (wb)
);

// File: test/exu_tb.sv
`timescale 1ns/100ps

module exu_tb;

   localparam int num_instr     = 2000;
   localparam int clk_period_ns = 4;
   localparam int timeout_ns    = num_instr * 20 * clk_period_ns;

   logic            clk;
   logic            rst_n;
   logic            issue_valid;
   logic            issue_ready;
   exu_pkg::issue_t issue;
   logic            wb_valid;
   logic            wb_ready;
   exu_pkg::wb_t    wb;

   logic [31:0]     rng_state;
   exu_pkg::data_t  model_regs [0:31];
   exu_pkg::wb_t    exp_q [$];
   int              data_errors  = 0;
   int              addr_errors  = 0;
   int              pc_errors    = 0;
   int              flag_errors  = 0;
   int              other_errors = 0;

   tb_clkgen #(
      .period_ns    (clk_period_ns),
      .reset_cycles (10)
   ) u_clkgen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   exu_top u_exu_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue       (issue),
      .wb_valid    (wb_valid),
      .wb_ready    (wb_ready),
      .wb          (wb)
   );

   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   // low LCG bits are weak, so words come from two upper halves
   function automatic logic [31:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_random();
      lo = next_random();
      return {hi[31:16], lo[31:16]};
   endfunction

   function automatic int rand_below(int n);
      logic [31:0] r;
      r = next_random();
      return int'(r[30:16]) % n;
   endfunction

   task automatic check_data(string name, exu_pkg::data_t got, exu_pkg::data_t exp);
      if (got !== exp) begin
         data_errors++;
         $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_addr(string name, exu_pkg::reg_addr_t got, exu_pkg::reg_addr_t exp);
      if (got !== exp) begin
         addr_errors++;
         $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_pc(string name, exu_pkg::pc_t got, exu_pkg::pc_t exp);
      if (got !== exp) begin
         pc_errors++;
         $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         flag_errors++;
         $display("error %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic compare_wb(string tag, exu_pkg::wb_t got, exu_pkg::wb_t exp);
      check_addr({tag, ".rd"}, got.rd, exp.rd);
      check_bit({tag, ".wen"}, got.wen, exp.wen);
      check_data({tag, ".data"}, got.data, exp.data);
      check_bit({tag, ".br_taken"}, got.br_taken, exp.br_taken);
      check_pc({tag, ".br_target"}, got.br_target, exp.br_target);
   endtask

   function automatic exu_pkg::data_t alu_model(exu_pkg::alu_op_e op,
                                                exu_pkg::data_t a, exu_pkg::data_t b);
      case (op)
         exu_pkg::alu_add:   return a + b;
         exu_pkg::alu_sub:   return a - b;
         exu_pkg::alu_and:   return a & b;
         exu_pkg::alu_or:    return a | b;
         exu_pkg::alu_xor:   return a ^ b;
         exu_pkg::alu_sll:   return a << b[4:0];
         exu_pkg::alu_srl:   return a >> b[4:0];
         exu_pkg::alu_sra:   return $signed(a) >>> b[4:0];
         exu_pkg::alu_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         exu_pkg::alu_sltu:  return (a < b) ? 32'd1 : 32'd0;
         exu_pkg::alu_passb: return b;
         default:            return '0;
      endcase
   endfunction

   // expected writeback from the model registers at acceptance
   function automatic exu_pkg::wb_t expected_result(exu_pkg::issue_t p);
      exu_pkg::wb_t   e;
      exu_pkg::data_t a;
      exu_pkg::data_t b;
      logic [63:0]    prod;
      a = model_regs[p.rs1];
      b = p.use_imm ? p.imm : model_regs[p.rs2];
      e = '0;
      e.rd = p.rd;
      case (p.unit)
         exu_pkg::unit_alu: begin
            e.wen  = 1'b1;
            e.data = alu_model(p.alu_op, a, b);
         end
         exu_pkg::unit_bru: begin
            case (p.bru_op)
               exu_pkg::bru_beq:  e.br_taken = (a == b);
               exu_pkg::bru_bne:  e.br_taken = (a != b);
               exu_pkg::bru_blt:  e.br_taken = ($signed(a) < $signed(b));
               exu_pkg::bru_bge:  e.br_taken = ($signed(a) >= $signed(b));
               exu_pkg::bru_bltu: e.br_taken = (a < b);
               exu_pkg::bru_bgeu: e.br_taken = (a >= b);
               default:           e.br_taken = 1'b1;
            endcase
            if (p.bru_op == exu_pkg::bru_jalr) begin
               e.br_target = (a + p.imm) & 32'hffff_fffe;
            end else begin
               e.br_target = p.pc + p.imm;
            end
            if (p.bru_op == exu_pkg::bru_jal || p.bru_op == exu_pkg::bru_jalr) begin
               e.wen  = 1'b1;
               e.data = p.pc + 32'd4;
            end
         end
         default: begin
            if (p.mul_op == exu_pkg::mul_mulhu) begin
               prod = {32'd0, a} * {32'd0, b};
            end else begin
               prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            end
            e.wen  = 1'b1;
            e.data = (p.mul_op == exu_pkg::mul_mul) ? prod[31:0] : prod[63:32];
         end
      endcase
      if (p.rd == '0) begin
         e.wen = 1'b0;
      end
      return e;
   endfunction

   function automatic exu_pkg::issue_t random_packet(exu_pkg::reg_addr_t last_rd);
      exu_pkg::issue_t p;
      logic [31:0]     pc_raw;
      p.unit   = exu_pkg::unit_e'(rand_below(3));
      p.alu_op = exu_pkg::alu_op_e'(rand_below(11));
      p.bru_op = exu_pkg::bru_op_e'(rand_below(8));
      p.mul_op = exu_pkg::mul_op_e'(rand_below(3));
      p.rs1    = exu_pkg::reg_addr_t'(rand_below(32));
      p.rs2    = exu_pkg::reg_addr_t'(rand_below(32));
      p.rd     = exu_pkg::reg_addr_t'(rand_below(32));
      // read back the previous destination now and then
      if (rand_below(4) == 0) begin
         p.rs1 = last_rd;
      end
      // equal sources make the eq and ge branch cases common
      if (rand_below(4) == 0) begin
         p.rs2 = p.rs1;
      end
      p.use_imm = (rand_below(3) == 0);
      p.imm     = rand_word();
      pc_raw    = rand_word();
      p.pc      = {pc_raw[31:2], 2'b00};
      return p;
   endfunction

   initial begin : watchdog
      #(timeout_ns);
      $display("timeout: the run did not finish within %0d ns", timeout_ns);
      $display("Result: FAILED");
      $finish;
   end

   initial begin : stimulus
      exu_pkg::wb_t       exp;
      exu_pkg::wb_t       wb_prev;
      exu_pkg::reg_addr_t last_rd;
      logic               accepted;
      logic               stalled;
      logic               acc_d1;
      logic               acc_d2;
      logic               rdy_d1;
      logic               rdy_d2;
      int                 sent;
      int                 total;
      rng_state   = 32'd55861;
      issue_valid = 1'b0;
      issue       = '0;
      wb_ready    = 1'b0;
      wb_prev     = '0;
      last_rd     = '0;
      accepted    = 1'b0;
      stalled     = 1'b0;
      acc_d1      = 1'b0;
      acc_d2      = 1'b0;
      rdy_d1      = 1'b0;
      rdy_d2      = 1'b0;
      sent        = 0;
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      wait (rst_n === 1'b1);
      @(negedge clk);
      #1;
      check_bit("issue_ready", issue_ready, 1'b1);
      check_bit("wb_valid", wb_valid, 1'b0);

      while (!(sent == num_instr && exp_q.size() == 0)) begin
         @(negedge clk);
         // a packet holds until it is accepted
         if (!issue_valid || accepted) begin
            if (sent < num_instr && rand_below(5) != 0) begin
               issue_valid = 1'b1;
               issue       = random_packet(last_rd);
               last_rd     = issue.rd;
            end else begin
               issue_valid = 1'b0;
            end
         end
         if (sent >= 1000 && sent < 1300) begin
            wb_ready = 1'b1;
         end else begin
            wb_ready = (rand_below(10) < 6);
         end

         // sample halfway to the rising edge
         #1;
         check_bit("issue_ready", issue_ready, !(wb_valid && !wb_ready));
         if (stalled) begin
            check_bit("stalled wb_valid", wb_valid, 1'b1);
            compare_wb("stalled wb", wb, wb_prev);
         end
         if (rdy_d1 && rdy_d2) begin
            check_bit("wb_valid latency", wb_valid, acc_d2);
         end
         accepted = issue_valid && issue_ready;

         // writeback lands before the same-edge operand read
         if (wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
               other_errors++;
               $display("a result came out with no instruction in flight");
            end else begin
               exp = exp_q.pop_front();
               compare_wb("wb", wb, exp);
               if (exp.wen) begin
                  model_regs[exp.rd] = exp.data;
               end
            end
         end
         if (accepted) begin
            exp_q.push_back(expected_result(issue));
            sent++;
         end

         stalled = wb_valid && !wb_ready;
         wb_prev = wb;
         acc_d2  = acc_d1;
         acc_d1  = accepted;
         rdy_d2  = rdy_d1;
         rdy_d1  = wb_ready;
      end

      @(negedge clk);
      issue_valid = 1'b0;
      wb_ready    = 1'b0;
      total = data_errors + addr_errors + pc_errors + flag_errors + other_errors;
      $display("errors: data %0d, addr %0d, pc %0d, flag %0d, other %0d",
               data_errors, addr_errors, pc_errors, flag_errors, other_errors);
      if (total == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: files.f
hdl/exu_pkg.sv
hdl/exu_regfile.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu_mul.sv
hdl/exu_ctrl.sv
hdl/exu_top.sv
test/tb_clkgen.sv
test/exu_sva.sv
test/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - hdl/exu_pkg.sv
  - hdl/exu_regfile.sv
  - hdl/exu_alu.sv
  - hdl/exu_bru.sv
  - hdl/exu_mul.sv
  - hdl/exu_ctrl.sv
  - hdl/exu_top.sv
  - target: test
    files:
      - test/tb_clkgen.sv
      - test/exu_sva.sv
      - test/exu_tb.sv
